//--- rtl/dcache_settings.svh
// data cache geometry settings shared by packages, RAMs and testbench
`ifndef DCACHE_SETTINGS_SVH
`define DCACHE_SETTINGS_SVH

// byte address width of the load/store unit
`define DC_ADDR_W 32

// address bits above set index and line offset
`define DC_TAG_W 23

// sets per way
`define DC_SETS 16

// bytes per cache line and per memory transfer
`define DC_LINE_BYTES 32

`endif

//--- rtl/cache_geom_pkg.sv
// cache geometry package with address field and tag-store types
`default_nettype none

`include "dcache_settings.svh"

package cache_geom_pkg;

    localparam int ADDR_W = `DC_ADDR_W;
    localparam int SETS = `DC_SETS;
    localparam int WAYS = 4; // fixed by the 3-bit plru tree
    localparam int DIRTY_BIT = `DC_TAG_W; // msb of a tag entry

    typedef logic [`DC_TAG_W-1:0] tag_t;
    typedef logic [$clog2(`DC_SETS)-1:0] set_idx_t;
    typedef logic [$clog2(`DC_LINE_BYTES)-3:0] word_sel_t;
    typedef logic [$clog2(WAYS)-1:0] way_idx_t;

    // dirty bit on top of the stored tag
    typedef logic [`DC_TAG_W:0] tag_entry_t;

    typedef logic [2:0] plru_state_t;

endpackage

`default_nettype wire

//--- rtl/cache_line_pkg.sv
// cache line package with the word/byte line union and line address type
`default_nettype none

`include "dcache_settings.svh"

package cache_line_pkg;

    // same 256 bits seen as words for reads or bytes for masked merges
    typedef union packed {
        logic [`DC_LINE_BYTES/4-1:0][31:0] words;
        logic [`DC_LINE_BYTES-1:0][7:0]    bytes;
    } cache_line_t;

    // byte address with the line offset dropped
    typedef logic [`DC_ADDR_W-$clog2(`DC_LINE_BYTES)-1:0] line_addr_t;

endpackage

`default_nettype wire

//--- rtl/line_sram.sv
// single-port registered-read RAM used for cache data and tag storage
`default_nettype none

`include "dcache_settings.svh"

module line_sram #(
    parameter int WIDTH = `DC_LINE_BYTES * 8,
    parameter int DEPTH = `DC_SETS
) (
    input  logic                     clk,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  logic                     we,
    input  logic [WIDTH-1:0]         din,
    output logic [WIDTH-1:0]         dout
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= din;
            dout <= din; // write-through to the read port
        end else begin
            dout <= mem[addr];
        end
    end

endmodule

`default_nettype wire

//--- rtl/cache_way.sv
// one cache way with data RAM, tag RAM, valid bits and hit/dirty status
`default_nettype none

module cache_way
    import cache_geom_pkg::*;
    import cache_line_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  set_idx_t    set_idx,
    input  tag_t        req_tag,
    input  logic        data_we,
    input  logic        tag_we,
    input  logic        valid_set,
    input  cache_line_t line_in,
    input  tag_entry_t  tag_in,
    output cache_line_t line_out,
    output tag_entry_t  tag_out,
    output logic        hit,
    output logic        dirty
);

    logic [SETS-1:0] valid;
    set_idx_t set_q;
    logic valid_q;

    line_sram #(
        .WIDTH($bits(cache_line_t)),
        .DEPTH(SETS)
    ) data_ram_i (
        .clk  (clk),
        .addr (set_idx),
        .we   (data_we),
        .din  (line_in),
        .dout (line_out)
    );

    line_sram #(
        .WIDTH($bits(tag_entry_t)),
        .DEPTH(SETS)
    ) tag_ram_i (
        .clk  (clk),
        .addr (set_idx),
        .we   (tag_we),
        .din  (tag_in),
        .dout (tag_out)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= '0;
        end else if (valid_set) begin
            valid[set_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        set_q <= set_idx; // aligns valid with RAM output
    end

    assign valid_q = valid[set_q];
    assign hit = valid_q && (tag_out[DIRTY_BIT-1:0] == req_tag);
    assign dirty = valid_q && tag_out[DIRTY_BIT];

endmodule

`default_nettype wire

//--- rtl/plru_tree.sv
// per-set tree pseudo-LRU state with victim selection and hit update
`default_nettype none

module plru_tree
    import cache_geom_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  set_idx_t set_idx,
    input  logic     touch,
    input  way_idx_t touch_way,
    output way_idx_t victim
);

    plru_state_t trees [SETS];
    plru_state_t cur;
    plru_state_t upd;

    assign cur = trees[set_idx];

    always_comb begin
        unique case (touch_way)
            2'd0:    upd = {cur[2], 2'b00};
            2'd1:    upd = {cur[2], 2'b10};
            2'd2:    upd = {1'b0, cur[1], 1'b1};
            default: upd = {1'b1, cur[1], 1'b1};
        endcase
    end

    // bit 0 picks the half, bits 1 and 2 the way within it
    assign victim = cur[0] ? (cur[1] ? 2'd0 : 2'd1)
                           : (cur[2] ? 2'd2 : 2'd3);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                trees[s] <= '0;
            end
        end else if (touch) begin
            trees[set_idx] <= upd;
        end
    end

endmodule

`default_nettype wire

//--- rtl/cache_ctrl.sv
// cache controller FSM for hits, write merge, write-back and line allocate
`default_nettype none

module cache_ctrl
    import cache_geom_pkg::*;
    import cache_line_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] ufp_addr,
    input  logic [3:0]        ufp_rmask,
    input  logic [3:0]        ufp_wmask,
    input  logic [31:0]       ufp_wdata,
    output logic [31:0]       ufp_rdata,
    output logic              ufp_resp,
    output logic [ADDR_W-1:0] dfp_addr,
    output logic              dfp_read,
    output logic              dfp_write,
    output cache_line_t       dfp_wdata,
    input  cache_line_t       dfp_rdata,
    input  logic              dfp_resp,
    input  cache_line_t       way_line [WAYS],
    input  tag_entry_t        way_tag [WAYS],
    input  logic [WAYS-1:0]   way_hit,
    input  logic [WAYS-1:0]   way_dirty,
    input  way_idx_t          victim,
    output logic [WAYS-1:0]   data_we,
    output logic [WAYS-1:0]   tag_we,
    output logic [WAYS-1:0]   valid_set,
    output cache_line_t       line_in,
    output tag_entry_t        tag_in,
    output logic              plru_touch,
    output way_idx_t          plru_way
);

    localparam logic [1:0] S_IDLE      = 2'd0;
    localparam logic [1:0] S_COMPARE   = 2'd1;
    localparam logic [1:0] S_WRITEBACK = 2'd2;
    localparam logic [1:0] S_ALLOCATE  = 2'd3;

    localparam int OFFSET_W = ADDR_W - $bits(line_addr_t);

    logic [1:0] state;
    logic [1:0] state_next;
    line_addr_t req_line;
    line_addr_t victim_line;
    tag_t req_tag;
    set_idx_t req_set;
    word_sel_t word_sel;
    way_idx_t hit_way;
    logic req_valid;
    logic any_hit;
    cache_line_t merged_line;

    assign req_line = ufp_addr[ADDR_W-1:OFFSET_W];
    assign req_tag = req_line[$bits(line_addr_t)-1 -: $bits(tag_t)];
    assign req_set = req_line[$bits(set_idx_t)-1:0];
    assign word_sel = ufp_addr[2 +: $bits(word_sel_t)];
    assign req_valid = (|ufp_rmask) || (|ufp_wmask);
    assign any_hit = |way_hit;
    assign victim_line = {way_tag[victim][DIRTY_BIT-1:0], req_set};

    always_comb begin
        hit_way = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin // lowest way wins
            if (way_hit[w]) begin
                hit_way = way_idx_t'(w);
            end
        end
    end

    // byte merge into the hit line
    always_comb begin
        merged_line = way_line[hit_way];
        for (int b = 0; b < 4; b++) begin
            if (ufp_wmask[b]) begin
                merged_line.bytes[{word_sel, 2'(b)}] = ufp_wdata[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= S_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        ufp_resp = 1'b0;
        ufp_rdata = '0;
        dfp_addr = '0;
        dfp_read = 1'b0;
        dfp_write = 1'b0;
        dfp_wdata = '0;
        data_we = '0;
        tag_we = '0;
        valid_set = '0;
        line_in = merged_line;
        tag_in = {1'b1, req_tag};
        plru_touch = 1'b0;
        plru_way = hit_way;

        unique case (state)
            S_IDLE: begin
                if (req_valid) begin
                    state_next = S_COMPARE;
                end
            end
            S_COMPARE: begin
                if (any_hit) begin
                    ufp_resp = 1'b1;
                    plru_touch = 1'b1;
                    state_next = S_IDLE;
                    if (|ufp_rmask) begin
                        ufp_rdata = way_line[hit_way].words[word_sel];
                    end else begin
                        data_we[hit_way] = 1'b1; // merged line with dirty tag
                        tag_we[hit_way] = 1'b1;
                    end
                end else if (way_dirty[victim]) begin
                    state_next = S_WRITEBACK;
                end else begin
                    state_next = S_ALLOCATE;
                end
            end
            S_WRITEBACK: begin
                dfp_write = 1'b1;
                dfp_addr = {victim_line, OFFSET_W'(0)};
                dfp_wdata = way_line[victim];
                if (dfp_resp) begin
                    state_next = S_ALLOCATE;
                end
            end
            S_ALLOCATE: begin
                dfp_read = 1'b1;
                dfp_addr = {req_line, OFFSET_W'(0)};
                line_in = dfp_rdata;
                tag_in = {1'b0, req_tag}; // fresh line is clean
                if (dfp_resp) begin
                    data_we[victim] = 1'b1;
                    tag_we[victim] = 1'b1;
                    valid_set[victim] = 1'b1;
                    state_next = S_IDLE; // request hits on the next compare
                end
            end
            default: state_next = S_IDLE;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/dcache_top.sv
// 4-way write-back data cache top with ways, PLRU and controller
`default_nettype none

module dcache_top
    import cache_geom_pkg::*;
    import cache_line_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst,
    input  logic [ADDR_W-1:0]              ufp_addr,
    input  logic [3:0]                     ufp_rmask,
    input  logic [3:0]                     ufp_wmask,
    input  logic [31:0]                    ufp_wdata,
    output logic [31:0]                    ufp_rdata,
    output logic                           ufp_resp,
    output logic [ADDR_W-1:0]              dfp_addr,
    output logic                           dfp_read,
    output logic                           dfp_write,
    output logic [$bits(cache_line_t)-1:0] dfp_wdata,
    input  logic [$bits(cache_line_t)-1:0] dfp_rdata,
    input  logic                           dfp_resp
);

    set_idx_t set_idx;
    tag_t req_tag;
    cache_line_t way_line [WAYS];
    tag_entry_t way_tag [WAYS];
    logic [WAYS-1:0] way_hit;
    logic [WAYS-1:0] way_dirty;
    logic [WAYS-1:0] data_we;
    logic [WAYS-1:0] tag_we;
    logic [WAYS-1:0] valid_set;
    cache_line_t line_in;
    tag_entry_t tag_in;
    logic plru_touch;
    way_idx_t plru_way;
    way_idx_t victim;

    assign req_tag = ufp_addr[ADDR_W-1 -: $bits(tag_t)];
    assign set_idx = ufp_addr[ADDR_W-$bits(tag_t)-1 -: $bits(set_idx_t)];

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        cache_way cache_way_i (
            .clk       (clk),
            .rst       (rst),
            .set_idx   (set_idx),
            .req_tag   (req_tag),
            .data_we   (data_we[w]),
            .tag_we    (tag_we[w]),
            .valid_set (valid_set[w]),
            .line_in   (line_in),
            .tag_in    (tag_in),
            .line_out  (way_line[w]),
            .tag_out   (way_tag[w]),
            .hit       (way_hit[w]),
            .dirty     (way_dirty[w])
        );
    end

    plru_tree plru_tree_i (
        .clk       (clk),
        .rst       (rst),
        .set_idx   (set_idx),
        .touch     (plru_touch),
        .touch_way (plru_way),
        .victim    (victim)
    );

    cache_ctrl cache_ctrl_i (
        .clk        (clk),
        .rst        (rst),
        .ufp_addr   (ufp_addr),
        .ufp_rmask  (ufp_rmask),
        .ufp_wmask  (ufp_wmask),
        .ufp_wdata  (ufp_wdata),
        .ufp_rdata  (ufp_rdata),
        .ufp_resp   (ufp_resp),
        .dfp_addr   (dfp_addr),
        .dfp_read   (dfp_read),
        .dfp_write  (dfp_write),
        .dfp_wdata  (dfp_wdata),
        .dfp_rdata  (dfp_rdata),
        .dfp_resp   (dfp_resp),
        .way_line   (way_line),
        .way_tag    (way_tag),
        .way_hit    (way_hit),
        .way_dirty  (way_dirty),
        .victim     (victim),
        .data_we    (data_we),
        .tag_we     (tag_we),
        .valid_set  (valid_set),
        .line_in    (line_in),
        .tag_in     (tag_in),
        .plru_touch (plru_touch),
        .plru_way   (plru_way)
    );

endmodule

`default_nettype wire

//--- tests/dcache_properties.sv
// memory-side protocol assertions for the data cache, bound to the top level
`default_nettype none

module dcache_properties (
    input logic        clk,
    input logic        rst,
    input logic        ufp_resp,
    input logic [31:0] dfp_addr,
    input logic        dfp_read,
    input logic        dfp_write,
    input logic        dfp_resp
);

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(dfp_read && dfp_write))
        else $error("dfp_read and dfp_write high together");

    a_resp_pulse: assert property (@(posedge clk) disable iff (rst)
        ufp_resp |=> !ufp_resp)
        else $error("ufp_resp lasted two cycles");

    a_read_held: assert property (@(posedge clk) disable iff (rst)
        (dfp_read && !dfp_resp) |=> dfp_read)
        else $error("dfp_read dropped before dfp_resp");

    a_write_held: assert property (@(posedge clk) disable iff (rst)
        (dfp_write && !dfp_resp) |=> dfp_write)
        else $error("dfp_write dropped before dfp_resp");

    a_line_aligned: assert property (@(posedge clk) disable iff (rst)
        (dfp_read || dfp_write) |-> (dfp_addr[4:0] == 5'd0))
        else $error("dfp_addr not line aligned");

endmodule

bind dcache_top dcache_properties dcache_properties_i (
    .clk       (clk),
    .rst       (rst),
    .ufp_resp  (ufp_resp),
    .dfp_addr  (dfp_addr),
    .dfp_read  (dfp_read),
    .dfp_write (dfp_write),
    .dfp_resp  (dfp_resp)
);

`default_nettype wire

//--- tests/dcache_tb.sv
// directed testbench for the 4-way write-back data cache with line memory model
`default_nettype none

`include "dcache_settings.svh"

module dcache_tb
    import cache_geom_pkg::*;
    import cache_line_pkg::*;
();

    logic clk;
    logic rst;
    logic [31:0] ufp_addr;
    logic [3:0] ufp_rmask;
    logic [3:0] ufp_wmask;
    logic [31:0] ufp_wdata;
    logic [31:0] ufp_rdata;
    logic ufp_resp;
    logic [31:0] dfp_addr;
    logic dfp_read;
    logic dfp_write;
    logic [255:0] dfp_wdata;
    logic [255:0] dfp_rdata;
    logic dfp_resp;

    cache_line_t mem [64];    // memory model indexed by {tag[2:0], set[2:0]}
    cache_line_t shadow [64]; // reference contents
    tag_t mtag [`DC_SETS][WAYS];
    logic mvalid [`DC_SETS][WAYS];
    logic mdirty [`DC_SETS][WAYS];
    plru_state_t mplru [`DC_SETS];
    int rd_count;
    int wr_count;
    int issued;
    logic [31:0] last_rd_addr;
    logic [31:0] wb_addr_q [$];
    logic [255:0] wb_line_q [$];
    logic [31:0] mem_seed = 32'd15886;
    logic [31:0] stim_seed = 32'd15886;

    dcache_top dcache_top_i (
        .clk       (clk),
        .rst       (rst),
        .ufp_addr  (ufp_addr),
        .ufp_rmask (ufp_rmask),
        .ufp_wmask (ufp_wmask),
        .ufp_wdata (ufp_wdata),
        .ufp_rdata (ufp_rdata),
        .ufp_resp  (ufp_resp),
        .dfp_addr  (dfp_addr),
        .dfp_read  (dfp_read),
        .dfp_write (dfp_write),
        .dfp_wdata (dfp_wdata),
        .dfp_rdata (dfp_rdata),
        .dfp_resp  (dfp_resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(inout logic [31:0] s);
        s = s * 32'd1103515245 + 32'd12345;
        return s >> 8;
    endfunction

    function automatic int mem_index(input logic [31:0] a);
        return int'({a[11:9], a[7:5]});
    endfunction

    function automatic logic [31:0] line_base(input int i);
        return {20'd0, i[5:3], 1'b0, i[2:0], 5'd0};
    endfunction

    function automatic logic [31:0] pattern_word(input logic [31:0] a);
        return (a * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    function automatic way_idx_t plru_victim(input plru_state_t s);
        if (s[0]) begin
            return s[1] ? 2'd0 : 2'd1;
        end
        return s[2] ? 2'd2 : 2'd3;
    endfunction

    function automatic plru_state_t plru_touch(input plru_state_t s, input way_idx_t w);
        case (w)
            2'd0:    return {s[2], 2'b00};
            2'd1:    return {s[2], 2'b10};
            2'd2:    return {1'b0, s[1], 1'b1};
            default: return {1'b1, s[1], 1'b1};
        endcase
    endfunction

    task automatic report_failure(input string msg);
        $display("CHECK FAILED at time %0t: %s", $time, msg);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    // line memory with random response latency
    initial begin
        int lat;
        int idx;
        dfp_resp = 1'b0;
        dfp_rdata = '0;
        forever begin
            @(negedge clk);
            if (!rst && (dfp_read || dfp_write)) begin
                lat = 1 + int'(lcg_step(mem_seed) % 4);
                repeat (lat - 1) @(negedge clk);
                idx = mem_index(dfp_addr);
                if (dfp_write) begin
                    mem[idx] = dfp_wdata;
                    wb_addr_q.push_back(dfp_addr);
                    wb_line_q.push_back(dfp_wdata);
                    wr_count++;
                end else begin
                    dfp_rdata = mem[idx];
                    last_rd_addr = dfp_addr;
                    rd_count++;
                end
                dfp_resp = 1'b1;
                @(negedge clk);
                dfp_resp = 1'b0;
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles > 10 + 200 * (issued + 1)) begin
                $display("timeout: the DUT stopped answering requests");
                $display("Simulation failed");
                $fatal(1, "watchdog expired");
            end
        end
    end

    // one CPU access checked against the shadow and the cache model
    task automatic access(input logic [31:0] addr, input logic [3:0] rmask,
                          input logic [3:0] wmask, input logic [31:0] wdata);
        int idx;
        int set;
        int lat;
        int rd0;
        int wr0;
        way_idx_t way;
        logic hit;
        logic exp_wb;
        logic [31:0] exp_word;
        logic [31:0] wb_addr;
        logic [255:0] wb_line;
        logic [31:0] got;
        assert (addr[31:12] == 0 && addr[8] == 0)
            else report_failure("address outside the memory model");
        idx = mem_index(addr);
        set = int'(addr[8:5]);
        hit = 1'b0;
        way = '0;
        exp_wb = 1'b0;
        wb_addr = '0;
        wb_line = '0;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (mvalid[set][w] && mtag[set][w] == addr[31:9]) begin
                hit = 1'b1;
                way = way_idx_t'(w);
            end
        end
        if (!hit) begin
            way = plru_victim(mplru[set]);
            if (mvalid[set][way] && mdirty[set][way]) begin
                exp_wb = 1'b1;
                wb_addr = {mtag[set][way], addr[8:5], 5'd0};
                wb_line = shadow[mem_index(wb_addr)];
            end
            mvalid[set][way] = 1'b1;
            mtag[set][way] = addr[31:9];
            mdirty[set][way] = 1'b0;
        end
        mplru[set] = plru_touch(mplru[set], way);
        if (|wmask) begin
            mdirty[set][way] = 1'b1;
        end
        exp_word = shadow[idx].words[addr[4:2]];
        rd0 = rd_count;
        wr0 = wr_count;
        issued++;

        @(negedge clk);
        ufp_addr = addr;
        ufp_rmask = rmask;
        ufp_wmask = wmask;
        ufp_wdata = wdata;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!ufp_resp);
        got = ufp_rdata;
        @(negedge clk);
        ufp_rmask = '0;
        ufp_wmask = '0;

        if (hit) begin
            assert (lat == 1)
                else report_failure($sformatf("hit at %h answered after %0d cycles", addr, lat));
            assert (rd_count == rd0 && wr_count == wr0)
                else report_failure($sformatf("memory strobe on hit at %h", addr));
        end else begin
            assert (rd_count == rd0 + 1 && last_rd_addr == {addr[31:5], 5'd0})
                else report_failure($sformatf("wrong line fill for miss at %h", addr));
            assert (wr_count == wr0 + int'(exp_wb))
                else report_failure($sformatf("write-back count wrong for miss at %h", addr));
            if (exp_wb) begin
                assert (wb_addr_q[$] == wb_addr && wb_line_q[$] == wb_line)
                    else report_failure($sformatf("bad write-back of line %h", wb_addr));
            end
        end
        for (int b = 0; b < 4; b++) begin
            if (rmask[b]) begin
                assert (got[8*b +: 8] == exp_word[8*b +: 8])
                    else report_failure($sformatf("read %h: got %h, expected %h",
                                                  addr, got, exp_word));
            end
            if (wmask[b]) begin
                shadow[idx].bytes[{addr[4:2], 2'(b)}] = wdata[8*b +: 8];
            end
        end
    endtask

    task automatic test_cold_miss();
        access(32'h0000_0014, 4'hf, 4'h0, '0);
    endtask

    task automatic test_read_hit();
        access(32'h0000_0014, 4'hf, 4'h0, '0);
        access(32'h0000_0008, 4'hf, 4'h0, '0);
    endtask

    task automatic test_write_merge();
        access(32'h0000_0004, 4'h0, 4'b0001, 32'hdead_beef);
        access(32'h0000_0010, 4'h0, 4'b0110, 32'h1234_5678);
        access(32'h0000_001c, 4'h0, 4'b1111, 32'hcafe_f00d);
        access(32'h0000_0004, 4'hf, 4'h0, '0);
        access(32'h0000_0010, 4'hf, 4'h0, '0);
        access(32'h0000_001c, 4'hf, 4'h0, '0);
    endtask

    // five tags in set 3
    task automatic test_replacement();
        int wb0;
        wb0 = wr_count;
        for (int t = 0; t < 5; t++) begin
            access({20'd0, 3'(t), 9'h060}, 4'hf, 4'h0, '0);
        end
        access(32'h0000_0460, 4'hf, 4'h0, '0);
        access(32'h0000_0264, 4'h0, 4'hf, 32'h0bad_cafe);
        access(32'h0000_0068, 4'h0, 4'h3, 32'h5555_aaaa);
        for (int t = 4; t >= 0; t--) begin
            access({20'd0, 3'(t), 9'h06c}, 4'hf, 4'h0, '0);
        end
        assert (wr_count > wb0)
            else report_failure("no dirty victim was written back");
    endtask

    task automatic test_random_mix();
        logic [31:0] r;
        logic [31:0] addr;
        logic [3:0] mask;
        for (int n = 0; n < 300; n++) begin
            r = lcg_step(stim_seed);
            addr = {20'd0, 1'b0, r[1:0], 1'b0, r[4:2], r[7:5], 2'b00};
            mask = r[11:8] == 0 ? 4'h1 : r[11:8];
            if (r[12]) begin
                access(addr, 4'h0, mask, lcg_step(stim_seed));
            end else begin
                access(addr, mask, 4'h0, '0);
            end
        end
        for (int s = 0; s < 8; s++) begin // evicts all tags 0..3
            for (int t = 4; t < 8; t++) begin
                access({20'd0, 3'(t), 1'b0, 3'(s), 5'd0}, 4'hf, 4'h0, '0);
            end
        end
        for (int i = 0; i < 32; i++) begin
            assert (mem[i] == shadow[i])
                else report_failure($sformatf("memory line %h differs", line_base(i)));
        end
    endtask

    initial begin
        rst = 1'b1;
        ufp_addr = '0;
        ufp_rmask = '0;
        ufp_wmask = '0;
        ufp_wdata = '0;
        rd_count = 0;
        wr_count = 0;
        issued = 0;
        last_rd_addr = '0;
        for (int i = 0; i < 64; i++) begin
            for (int k = 0; k < 8; k++) begin
                mem[i].words[k] = pattern_word(line_base(i) + 32'(4 * k));
            end
            shadow[i] = mem[i];
        end
        for (int s = 0; s < `DC_SETS; s++) begin
            mplru[s] = '0;
            for (int w = 0; w < WAYS; w++) begin
                mvalid[s][w] = 1'b0;
                mdirty[s][w] = 1'b0;
                mtag[s][w] = '0;
            end
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_cold_miss();
        test_read_hit();
        test_write_merge();
        test_replacement();
        test_random_mix();

        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/cache_geom_pkg.sv
rtl/cache_line_pkg.sv
rtl/line_sram.sv
rtl/cache_way.sv
rtl/plru_tree.sv
rtl/cache_ctrl.sv
rtl/dcache_top.sv
tests/dcache_properties.sv
tests/dcache_tb.sv

//--- Makefile
.PHONY: help test clean

help:
	@echo "make test  - build with Verilator and run the testbench"
	@echo "make clean - remove build output"
	@echo "make help  - list these targets"

test:
	verilator --binary --assert --timing --top-module dcache_tb \
		-f src.f --Mdir obj_dir -o dcache_sim
	@out=$$(./obj_dir/dcache_sim); status=$$?; echo "$$out"; \
		echo "$$out" | grep -q "Simulation passed"

clean:
	rm -rf obj_dir
